// ==== files.f ====
+incdir+tests
src/icap_pkg.sv
src/icap_session_ctrl.sv
src/icap_word_fifo.sv
src/icap_port_writer.sv
src/phy_reset_gen.sv
src/icap_bridge_top.sv
tests/tb_icap_bridge.sv

// ==== src/icap_bridge_top.sv ====
`timescale 1ns/100ps

module icap_bridge_top #(
	parameter int FIFO_DEPTH = icap_pkg::DEFAULT_FIFO_DEPTH,
	parameter int FLUSH_CYCLES = icap_pkg::DEFAULT_FLUSH_CYCLES,
	parameter int PHY_RST_HOLD = icap_pkg::DEFAULT_PHY_RST_HOLD
) (
	input  logic pcie_clk,
	input  logic icap_reset_delay,
	input  logic open_i,
	input  logic quiesce_i,
	input  logic wr_valid_i,
	input  icap_pkg::cfg_word_t wr_data_i,
	output logic wr_ready_o,
	output logic icap_ce_n_o,
	output logic icap_write_n_o,
	output icap_pkg::cfg_word_t icap_data_o,
	output logic icap_busy_o,
	output logic phy_rst_o
);

	// controller <-> fifo
	logic fifo_push;
	logic fifo_flush;
	logic fifo_empty;
	logic fifo_full;
	// fifo <-> writer
	logic fifo_pop;
	icap_pkg::cfg_word_t fifo_data;
	// quiesce after the two-stage pipe
	logic drain_en;

	//////////////////////////////////////////////////////////////////////
	// session control and word buffer
	//////////////////////////////////////////////////////////////////////

	icap_session_ctrl #(.FLUSH_CYCLES(FLUSH_CYCLES)) u_ctrl (
		.pcie_clk(pcie_clk),
		.icap_reset_delay(icap_reset_delay),
		.open_i(open_i),
		.quiesce_i(quiesce_i),
		.wr_valid_i(wr_valid_i),
		.fifo_full_i(fifo_full),
		.fifo_empty_i(fifo_empty),
		.wr_ready_o(wr_ready_o),
		.push_o(fifo_push),
		.flush_o(fifo_flush),
		.drain_en_o(drain_en),
		.icap_busy_o(icap_busy_o)
	);

	icap_word_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) u_fifo (
		.pcie_clk(pcie_clk),
		.icap_reset_delay(icap_reset_delay),
		.push_i(fifo_push),
		.wr_data_i(wr_data_i),
		.pop_i(fifo_pop),
		.flush_i(fifo_flush),
		.rd_data_o(fifo_data),
		.empty_o(fifo_empty),
		.full_o(fifo_full)
	);

	//////////////////////////////////////////////////////////////////////
	// configuration port and phy reset
	//////////////////////////////////////////////////////////////////////

	icap_port_writer u_writer (
		.pcie_clk(pcie_clk),
		.icap_reset_delay(icap_reset_delay),
		.drain_en_i(drain_en),
		.fifo_empty_i(fifo_empty),
		.fifo_data_i(fifo_data),
		.pop_o(fifo_pop),
		.icap_ce_n_o(icap_ce_n_o),
		.icap_write_n_o(icap_write_n_o),
		.icap_data_o(icap_data_o)
	);

	// link reset follows the same piped quiesce as the drain
	phy_reset_gen #(.PHY_RST_HOLD(PHY_RST_HOLD)) u_phy_rst (
		.pcie_clk(pcie_clk),
		.icap_reset_delay(icap_reset_delay),
		.quiesce_q_i(drain_en),
		.phy_rst_o(phy_rst_o)
	);

endmodule

// ==== src/icap_pkg.sv ====
package icap_pkg;

	//////////////////////////////////////////////////////////////////////
	// configuration word
	//////////////////////////////////////////////////////////////////////

	// width of one word on the configuration port
	localparam int CFG_WORD_W = 16;

	// one configuration word as it travels host -> fifo -> port
	typedef logic [CFG_WORD_W-1:0] cfg_word_t;

	//////////////////////////////////////////////////////////////////////
	// session controller
	//////////////////////////////////////////////////////////////////////

	// idle: no open seen since reset
	// flush: fifo being emptied, host writes refused
	// accept: host writes taken into the fifo
	typedef enum logic [1:0] {
		SESSION_IDLE,
		SESSION_FLUSH,
		SESSION_ACCEPT
	} session_state_t;

	//////////////////////////////////////////////////////////////////////
	// defaults picked up by the top level
	//////////////////////////////////////////////////////////////////////

	// words buffered between host and configuration port
	localparam int DEFAULT_FIFO_DEPTH = 16;
	// cycles writes stay refused after each open
	localparam int DEFAULT_FLUSH_CYCLES = 32;
	// minimum high time of the phy reset, same as a 32-deep srl
	localparam int DEFAULT_PHY_RST_HOLD = 32;

endpackage

// ==== src/icap_port_writer.sv ====
`timescale 1ns/100ps

module icap_port_writer (
	input  logic pcie_clk,
	input  logic icap_reset_delay,
	input  logic drain_en_i,
	input  logic fifo_empty_i,
	input  icap_pkg::cfg_word_t fifo_data_i,
	output logic pop_o,
	output logic icap_ce_n_o,
	output logic icap_write_n_o,
	output icap_pkg::cfg_word_t icap_data_o
);

	logic ce_n_q;
	logic write_n_q;
	icap_pkg::cfg_word_t data_q;

	// pop one word per cycle while draining and data is there
	assign pop_o = drain_en_i && !fifo_empty_i;

	// strobes, both active low and both low only in the cycle after a pop
	always_ff @(posedge pcie_clk) begin
		if (icap_reset_delay) begin
			ce_n_q <= 1'b1;
			write_n_q <= 1'b1;
		end else begin
			ce_n_q <= !pop_o;
			write_n_q <= !pop_o;
		end
	end

	// port data, holds the last word when idle
	always_ff @(posedge pcie_clk) begin
		if (pop_o) data_q <= fifo_data_i;
	end

	assign icap_ce_n_o = ce_n_q;
	assign icap_write_n_o = write_n_q;
	assign icap_data_o = data_q;

endmodule

// ==== src/icap_session_ctrl.sv ====
`timescale 1ns/100ps

module icap_session_ctrl #(
	parameter int FLUSH_CYCLES = icap_pkg::DEFAULT_FLUSH_CYCLES
) (
	input  logic pcie_clk,
	input  logic icap_reset_delay,
	input  logic open_i,
	input  logic quiesce_i,
	input  logic wr_valid_i,
	input  logic fifo_full_i,
	input  logic fifo_empty_i,
	output logic wr_ready_o,
	output logic push_o,
	output logic flush_o,
	output logic drain_en_o,
	output logic icap_busy_o
);

	// counter wide enough for the last flush cycle index
	localparam int CNT_W = $clog2(FLUSH_CYCLES + 1);

	icap_pkg::session_state_t state_q;
	logic [CNT_W-1:0] flush_cnt_q;
	// [0] is open as sampled, [1] is the previous sample
	logic [1:0] open_q;
	// two stages, the old cross-clock sync now just a pipe
	logic [1:0] quiesce_q;
	logic busy_q;
	logic open_rise;
	logic flush_done;

	// rising edge of the registered open flag
	assign open_rise = open_q[0] && !open_q[1];
	assign flush_done = (flush_cnt_q == CNT_W'(FLUSH_CYCLES - 1));

	//////////////////////////////////////////////////////////////////////
	// session fsm
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge pcie_clk) begin
		if (icap_reset_delay) begin
			state_q <= icap_pkg::SESSION_IDLE;
			flush_cnt_q <= '0;
			open_q <= 2'b00;
		end else begin
			open_q <= {open_q[0], open_i};
			// a new open restarts the flush whatever the state
			if (open_rise) begin
				state_q <= icap_pkg::SESSION_FLUSH;
				flush_cnt_q <= '0;
			end else if (state_q == icap_pkg::SESSION_FLUSH) begin
				// hold off writes for FLUSH_CYCLES cycles
				if (flush_done) state_q <= icap_pkg::SESSION_ACCEPT;
				else flush_cnt_q <= flush_cnt_q + 1'b1;
			end
		end
	end

	// fifo flush for the whole flush window
	assign flush_o = (state_q == icap_pkg::SESSION_FLUSH);

	// host handshake, full fifo back-pressures the host
	assign wr_ready_o = (state_q == icap_pkg::SESSION_ACCEPT) && !fifo_full_i;
	assign push_o = wr_valid_i && wr_ready_o;

	//////////////////////////////////////////////////////////////////////
	// quiesce pipe and busy flag
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge pcie_clk) begin
		if (icap_reset_delay) begin
			quiesce_q <= 2'b00;
			busy_q <= 1'b0;
		end else begin
			quiesce_q <= {quiesce_q[0], quiesce_i};
			// set on first buffered word, only an open clears it
			// stays clear through the flush while the fifo empties
			if (open_rise || flush_o) busy_q <= 1'b0;
			else if (!fifo_empty_i) busy_q <= 1'b1;
		end
	end

	assign drain_en_o = quiesce_q[1];
	assign icap_busy_o = busy_q;

endmodule

// ==== src/icap_word_fifo.sv ====
`timescale 1ns/100ps

module icap_word_fifo #(
	parameter int FIFO_DEPTH = icap_pkg::DEFAULT_FIFO_DEPTH
) (
	input  logic pcie_clk,
	input  logic icap_reset_delay,
	input  logic push_i,
	input  icap_pkg::cfg_word_t wr_data_i,
	input  logic pop_i,
	input  logic flush_i,
	output icap_pkg::cfg_word_t rd_data_o,
	output logic empty_o,
	output logic full_o
);

	// pointer and occupancy widths come from the depth
	localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
	localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

	icap_pkg::cfg_word_t mem [FIFO_DEPTH];
	logic [PTR_W-1:0] wr_ptr_q;
	logic [PTR_W-1:0] rd_ptr_q;
	logic [CNT_W-1:0] count_q;
	logic do_push;
	logic do_pop;

	// wrap at the depth, which need not be a power of two
	function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
		if (ptr == PTR_W'(FIFO_DEPTH - 1)) return '0;
		return ptr + 1'b1;
	endfunction

	// guard both sides so a stray strobe cannot corrupt the count
	assign do_push = push_i && !full_o;
	assign do_pop = pop_i && !empty_o;

	// word storage, no reset needed on payload
	always_ff @(posedge pcie_clk) begin
		if (do_push) mem[wr_ptr_q] <= wr_data_i;
	end

	// pointers and count
	always_ff @(posedge pcie_clk) begin
		if (icap_reset_delay || flush_i) begin
			// flush drops everything in one cycle
			wr_ptr_q <= '0;
			rd_ptr_q <= '0;
			count_q <= '0;
		end else begin
			if (do_push) wr_ptr_q <= ptr_inc(wr_ptr_q);
			if (do_pop) rd_ptr_q <= ptr_inc(rd_ptr_q);
			// simultaneous push and pop leaves the count alone
			if (do_push && !do_pop) count_q <= count_q + 1'b1;
			else if (do_pop && !do_push) count_q <= count_q - 1'b1;
		end
	end

	// head word, valid whenever not empty
	assign rd_data_o = mem[rd_ptr_q];
	assign empty_o = (count_q == '0);
	assign full_o = (count_q == CNT_W'(FIFO_DEPTH));

endmodule

// ==== src/phy_reset_gen.sv ====
`timescale 1ns/100ps

module phy_reset_gen #(
	parameter int PHY_RST_HOLD = icap_pkg::DEFAULT_PHY_RST_HOLD
) (
	input  logic pcie_clk,
	input  logic icap_reset_delay,
	input  logic quiesce_q_i,
	output logic phy_rst_o
);

	// delay line of the flag itself, oldest sample at the top
	logic [PHY_RST_HOLD-1:0] delay_q;
	logic phy_rst_q;
	logic rst_delayed;
	logic rst_next;

	//////////////////////////////////////////////////////////////////////
	// delay line
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge pcie_clk) begin
		if (icap_reset_delay) delay_q <= '0;
		else delay_q <= {delay_q[PHY_RST_HOLD-2:0], phy_rst_q};
	end

	// flag as it was PHY_RST_HOLD cycles ago
	assign rst_delayed = delay_q[PHY_RST_HOLD-1];

	//////////////////////////////////////////////////////////////////////
	// reset flag
	//////////////////////////////////////////////////////////////////////

	// quiesce forces it high
	// otherwise stay high until the delayed copy catches up
	assign rst_next = quiesce_q_i || (phy_rst_q && !rst_delayed);

	always_ff @(posedge pcie_clk) begin
		// reset presets the flag
		if (icap_reset_delay) phy_rst_q <= 1'b1;
		else phy_rst_q <= rst_next;
	end

	assign phy_rst_o = phy_rst_q;

endmodule

// ==== tests/tb_icap_tasks.svh ====
// stop the run with a plain-words reason
task automatic abort_run(input string what);
	$display("ERROR: %s", what);
	$display("TESTBENCH FAILED");
	$fatal(1);
endtask

// compare one value against its expected value
task automatic check_value(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
	if (actual !== expected) begin
		$display("CHECK FAILED: %s actual 0x%0h expected 0x%0h", name, actual, expected);
		$display("TESTBENCH FAILED");
		$fatal(1);
	end
endtask

// advance n cycles, landing 2 ns after the edge
task automatic step_cycles(input int n);
	repeat (n) @(posedge pcie_clk);
	#2;
endtask

// wait for the write port to open, limit in cycles
task automatic wait_ready(input int limit);
	int waited;
	waited = 0;
	while (!wr_ready_o) begin
		if (waited >= limit) abort_run("wr_ready_o did not rise in time");
		step_cycles(1);
		waited++;
	end
endtask

// one host transfer, valid held until ready
task automatic write_word(input icap_pkg::cfg_word_t word);
	wr_valid_i = 1'b1;
	wr_data_i = word;
	wait_ready(WRITE_LIMIT);
	step_cycles(1);
	wr_valid_i = 1'b0;
	exp_q.push_back(word);
endtask

// wait until the port has shown n words
task automatic wait_words(input int n, input int limit);
	int waited;
	waited = 0;
	while (seen_q.size() < n) begin
		if (waited >= limit) abort_run("configuration port stopped before all words came out");
		step_cycles(1);
		waited++;
	end
endtask

// port stream against the model, both emptied afterwards
task automatic compare_streams();
	int i;
	check_value("word count", seen_q.size(), exp_q.size());
	for (i = 0; i < exp_q.size(); i++) check_value("icap_data_o", seen_q[i], exp_q[i]);
	seen_q.delete();
	exp_q.delete();
endtask

//////////////////////////////////////////////////////////////////////
// directed tests
//////////////////////////////////////////////////////////////////////

task automatic test_reset_state();
	int waited;
	check_value("wr_ready_o", wr_ready_o, 0);
	check_value("icap_busy_o", icap_busy_o, 0);
	check_value("icap_ce_n_o", icap_ce_n_o, 1);
	check_value("icap_write_n_o", icap_write_n_o, 1);
	check_value("phy_rst_o", phy_rst_o, 1);
	// minimum hold, then release with quiesce low
	waited = 0;
	while (phy_rst_o) begin
		if (waited >= PHY_RST_HOLD + 4) abort_run("phy_rst_o did not fall after its hold time");
		step_cycles(1);
		waited++;
	end
	if (waited < PHY_RST_HOLD) abort_run("phy_rst_o fell before its minimum hold time");
endtask

task automatic test_open_flush();
	int i;
	int waited;
	open_i = 1'b1;
	// ready stays low through the whole flush window
	waited = 0;
	while (!wr_ready_o) begin
		if (waited >= FLUSH_CYCLES + 2) abort_run("wr_ready_o did not rise after the open");
		step_cycles(1);
		waited++;
	end
	if (waited < FLUSH_CYCLES) abort_run("wr_ready_o rose before the flush was over");
	for (i = 0; i < 6; i++) write_word(icap_pkg::cfg_word_t'($random(seed)));
	step_cycles(2);
	check_value("icap_busy_o", icap_busy_o, 1);
	// nothing leaves without quiesce
	check_value("strobe count", seen_q.size(), 0);
endtask

task automatic test_quiesce_drain();
	quiesce_i = 1'b1;
	wait_words(exp_q.size(), FIFO_DEPTH + 8);
	// a few idle cycles to catch any extra word
	step_cycles(4);
	check_value("phy_rst_o", phy_rst_o, 1);
	compare_streams();
	quiesce_i = 1'b0;
	// let the piped quiesce die out before new writes
	step_cycles(4);
endtask

task automatic test_back_pressure();
	int i;
	for (i = 0; i < FIFO_DEPTH; i++) begin
		check_value("wr_ready_o", wr_ready_o, 1);
		write_word(icap_pkg::cfg_word_t'($random(seed)));
	end
	check_value("wr_ready_o", wr_ready_o, 0);
	quiesce_i = 1'b1;
	wait_words(FIFO_DEPTH, FIFO_DEPTH + 8);
	step_cycles(4);
	check_value("wr_ready_o", wr_ready_o, 1);
	compare_streams();
	quiesce_i = 1'b0;
	step_cycles(4);
endtask

task automatic test_reopen_discard();
	int i;
	int waited;
	for (i = 0; i < 5; i++) write_word(icap_pkg::cfg_word_t'($random(seed)));
	step_cycles(2);
	check_value("icap_busy_o", icap_busy_o, 1);
	open_i = 1'b0;
	step_cycles(2);
	open_i = 1'b1;
	waited = 0;
	while (icap_busy_o) begin
		if (waited >= 4) abort_run("icap_busy_o did not fall after the reopen");
		step_cycles(1);
		waited++;
	end
	wait_ready(FLUSH_CYCLES + 2);
	exp_q.delete();
	// quiesce window over an empty fifo
	quiesce_i = 1'b1;
	step_cycles(FIFO_DEPTH + 8);
	check_value("strobe count", seen_q.size(), 0);
	check_value("icap_busy_o", icap_busy_o, 0);
	quiesce_i = 1'b0;
	step_cycles(4);
endtask

// ==== tests/tb_icap_bridge.sv ====
`timescale 1ns/100ps

module tb_icap_bridge;

	//////////////////////////////////////////////////////////////////////
	// parameters and timing
	//////////////////////////////////////////////////////////////////////

	localparam int FIFO_DEPTH = icap_pkg::DEFAULT_FIFO_DEPTH;
	localparam int FLUSH_CYCLES = icap_pkg::DEFAULT_FLUSH_CYCLES;
	localparam int PHY_RST_HOLD = icap_pkg::DEFAULT_PHY_RST_HOLD;
	localparam int CLK_PERIOD = 20;
	localparam int RESET_CYCLES = 16;
	// worst case of one test: a flush, a full fifo in and out, a phy reset hold
	localparam int NUM_TESTS = 5;
	localparam int TEST_CYCLES = 4 * FIFO_DEPTH + 2 * FLUSH_CYCLES + 2 * PHY_RST_HOLD + 64;
	localparam int WATCHDOG_CYCLES = RESET_CYCLES + NUM_TESTS * TEST_CYCLES;
	// longest a host write may wait for ready
	localparam int WRITE_LIMIT = FIFO_DEPTH + FLUSH_CYCLES + 8;

	logic pcie_clk;
	logic icap_reset_delay;
	logic open_i;
	logic quiesce_i;
	logic wr_valid_i;
	icap_pkg::cfg_word_t wr_data_i;
	logic wr_ready_o;
	logic icap_ce_n_o;
	logic icap_write_n_o;
	icap_pkg::cfg_word_t icap_data_o;
	logic icap_busy_o;
	logic phy_rst_o;

	// model of written words and words seen on the port
	icap_pkg::cfg_word_t exp_q[$];
	icap_pkg::cfg_word_t seen_q[$];
	integer seed;

	`include "tb_icap_tasks.svh"

	icap_bridge_top #(
		.FIFO_DEPTH(FIFO_DEPTH),
		.FLUSH_CYCLES(FLUSH_CYCLES),
		.PHY_RST_HOLD(PHY_RST_HOLD)
	) u_dut (
		.pcie_clk(pcie_clk),
		.icap_reset_delay(icap_reset_delay),
		.open_i(open_i),
		.quiesce_i(quiesce_i),
		.wr_valid_i(wr_valid_i),
		.wr_data_i(wr_data_i),
		.wr_ready_o(wr_ready_o),
		.icap_ce_n_o(icap_ce_n_o),
		.icap_write_n_o(icap_write_n_o),
		.icap_data_o(icap_data_o),
		.icap_busy_o(icap_busy_o),
		.phy_rst_o(phy_rst_o)
	);

	// 20 ns clock
	initial pcie_clk = 1'b0;
	always #(CLK_PERIOD / 2) pcie_clk = ~pcie_clk;

	// port monitor, sampled mid-cycle where the outputs are settled
	// a word counts only with both strobes low together
	always @(negedge pcie_clk) begin
		if (!icap_reset_delay) begin
			if (!icap_ce_n_o && !icap_write_n_o) seen_q.push_back(icap_data_o);
			else if (!icap_ce_n_o || !icap_write_n_o)
				abort_run("only one of the configuration port strobes went low");
		end
	end

	// watchdog
	initial begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		abort_run("watchdog expired, the tests did not finish in time");
	end

	//////////////////////////////////////////////////////////////////////
	// test sequence
	//////////////////////////////////////////////////////////////////////

	initial begin
		seed = 78;
		icap_reset_delay = 1'b1;
		open_i = 1'b0;
		quiesce_i = 1'b0;
		wr_valid_i = 1'b0;
		wr_data_i = '0;
		repeat (RESET_CYCLES) @(posedge pcie_clk);
		#2;
		icap_reset_delay = 1'b0;
		test_reset_state();
		test_open_flush();
		test_quiesce_drain();
		test_back_pressure();
		test_reopen_discard();
		$display("TESTBENCH PASSED");
		$finish;
	end

endmodule
